/* Makefile */
TOP   := tb_fir
FLIST := fir_filter.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --top-module $(TOP) -f $(FLIST) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "TEST OK" sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* fir_filter.f */
source/fir_pkg.sv
source/word_ram.sv
source/fir_mac.sv
source/fir_regs.sv
source/fir_sequencer.sv
source/fir_top.sv
test/tb_fir.sv

/* source/fir_mac.sv */
`timescale 1ns/1ns

module fir_mac
    import fir_pkg::*;
(
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic [DATA_W-1:0] tap_word,
    input  logic [DATA_W-1:0] sample_word,
    input  logic              acc_clear,
    input  logic              acc_en,
    output logic [DATA_W-1:0] acc
);

    logic [DATA_W-1:0] h_q;
    logic [DATA_W-1:0] x_q;
    logic [DATA_W-1:0] prod_q;

    // operand and product stages, low 32 bits kept
    always_ff @(posedge axis_clk) begin
        h_q    <= tap_word;
        x_q    <= sample_word;
        prod_q <= h_q * x_q;
    end

    // wrapping sum, restarted for every new sample
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            acc <= '0;
        end else if (acc_clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc + prod_q;
        end
    end

endmodule

/* source/fir_pkg.sv */
package fir_pkg;

    ////////////////////
    // widths

    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;

    ////////////////////
    // register map

    localparam logic [ADDR_W-1:0] REG_AP_CTRL  = 12'h000;
    localparam logic [ADDR_W-1:0] REG_DATA_LEN = 12'h010;
    localparam logic [ADDR_W-1:0] REG_TAP_NUM  = 12'h014;
    // 0x80 up to 0xff, one coefficient per word
    localparam logic [ADDR_W-1:0] REG_TAP_BASE = 12'h080;

    // control word bits
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;

    ////////////////////
    // bundles

    // run setup, held between runs
    typedef struct packed {
        logic [31:0] data_len;
        logic [5:0]  tap_num;
    } fir_cfg_t;

    // one access to a word RAM
    typedef struct packed {
        logic              en;
        logic              we;
        logic [7:0]        addr;
        logic [DATA_W-1:0] wdata;
    } ram_req_t;

endpackage

/* source/fir_regs.sv */
`timescale 1ns/1ns

module fir_regs
    import fir_pkg::*;
#(
    parameter int TAP_MAX = 32
) (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              awvalid,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              wvalid,
    input  logic [DATA_W-1:0] wdata,
    output logic              awready,
    output logic              wready,
    input  logic              arvalid,
    input  logic [ADDR_W-1:0] araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [DATA_W-1:0] rdata,
    input  logic              rready,
    input  logic              ap_done,
    input  logic              ap_idle,
    output fir_cfg_t          cfg,
    output logic              ap_start,
    output logic              status_rd,
    output ram_req_t          tap_req
);

    logic              wr_fire;
    logic              rd_fire;
    logic              tap_hit;
    logic [ADDR_W-1:0] tap_off;
    logic [DATA_W-1:0] ctrl_word;
    logic [DATA_W-1:0] rd_word;

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    ////////////////////
    // write side

    // address and data accepted together, only while idle
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && ap_idle && !awready;
            wready  <= awvalid && wvalid && ap_idle && !awready;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            cfg <= '0;
        end else if (wr_fire) begin
            if (awaddr == REG_DATA_LEN) begin
                cfg.data_len <= wdata;
            end
            if (awaddr == REG_TAP_NUM) begin
                cfg.tap_num <= wdata[5:0];
            end
        end
    end

    assign ap_start = wr_fire && (awaddr == REG_AP_CTRL) && wdata[AP_START_BIT];

    // coefficient window, word index from the base
    assign tap_off = awaddr - REG_TAP_BASE;
    assign tap_hit = (awaddr[ADDR_W-1:7] == REG_TAP_BASE[ADDR_W-1:7])
                   && (int'(tap_off[ADDR_W-1:2]) < TAP_MAX);

    always_comb begin
        tap_req.en    = wr_fire && tap_hit;
        tap_req.we    = wr_fire && tap_hit;
        tap_req.addr  = tap_off[9:2];
        tap_req.wdata = wdata;
    end

    ////////////////////
    // read side

    always_comb begin
        ctrl_word               = '0;
        ctrl_word[AP_START_BIT] = ap_start;
        ctrl_word[AP_DONE_BIT]  = ap_done;
        ctrl_word[AP_IDLE_BIT]  = ap_idle;
    end

    always_comb begin
        case (araddr)
            REG_AP_CTRL:  rd_word = ctrl_word;
            REG_DATA_LEN: rd_word = cfg.data_len;
            REG_TAP_NUM:  rd_word = DATA_W'(cfg.tap_num);
            default:      rd_word = '0;
        endcase
    end

    // done is cleared by the sequencer once the word is captured
    assign status_rd = rd_fire && (araddr == REG_AP_CTRL);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

endmodule

/* source/fir_sequencer.sv */
`timescale 1ns/1ns

module fir_sequencer
    import fir_pkg::*;
#(
    parameter int TAP_MAX = 32
) (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  fir_cfg_t          cfg,
    input  logic              ap_start,
    input  logic              status_rd,
    input  logic              ss_tvalid,
    input  logic [DATA_W-1:0] ss_tdata,
    output logic              ss_tready,
    input  logic              sm_tready,
    output logic              sm_tvalid,
    output logic              sm_tlast,
    output logic              ap_done,
    output logic              ap_idle,
    output ram_req_t          tap_seq_req,
    output ram_req_t          sample_req,
    output logic              acc_clear,
    output logic              acc_en
);

    localparam int            IW       = $clog2(TAP_MAX);
    localparam logic [IW-1:0] LAST_IDX = IW'(TAP_MAX - 1);

    typedef enum logic [2:0] {
        S_CLEAR,
        S_IDLE,
        S_WAIT,
        S_PROC,
        S_OUT,
        S_DONE
    } state_t;

    state_t        state;
    logic          boot;
    logic [IW-1:0] clr_cnt;
    logic [IW-1:0] wptr;
    logic [IW-1:0] s_idx;
    logic [5:0]    k;
    logic [2:0]    pair_vld;
    logic [31:0]   out_cnt;
    logic          ss_fire;
    logic          sm_fire;
    logic          issue;

    function automatic logic [IW-1:0] ring_next(input logic [IW-1:0] idx);
        return (idx == LAST_IDX) ? '0 : idx + 1'b1;
    endfunction

    function automatic logic [IW-1:0] ring_prev(input logic [IW-1:0] idx);
        return (idx == '0) ? LAST_IDX : idx - 1'b1;
    endfunction

    assign ss_fire   = ss_tready && ss_tvalid;
    assign sm_fire   = sm_tvalid && sm_tready;
    assign issue     = (state == S_PROC) && (k < cfg.tap_num);
    assign ap_idle   = (state == S_IDLE);
    assign sm_tvalid = (state == S_OUT);
    assign sm_tlast  = sm_tvalid && (out_cnt == cfg.data_len);
    assign acc_clear = ss_fire;
    // ram read, word regs, product reg, then accumulate
    assign acc_en    = pair_vld[2];

    ////////////////////
    // run control

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= S_CLEAR;
            boot      <= 1'b1;
            clr_cnt   <= '0;
            wptr      <= '0;
            s_idx     <= '0;
            k         <= '0;
            out_cnt   <= '0;
            ss_tready <= 1'b0;
        end else begin
            ss_tready <= (state == S_WAIT) && ss_tvalid && !ss_tready;
            case (state)
                S_CLEAR: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    if (clr_cnt == LAST_IDX) begin
                        clr_cnt <= '0;
                        boot    <= 1'b0;
                        state   <= boot ? S_IDLE : S_WAIT;
                    end
                end
                S_IDLE: begin
                    if (ap_start) begin
                        wptr    <= '0;
                        out_cnt <= '0;
                        state   <= S_CLEAR;
                    end
                end
                S_WAIT: begin
                    if (ss_fire) begin
                        s_idx   <= wptr;
                        wptr    <= ring_next(wptr);
                        k       <= '0;
                        out_cnt <= out_cnt + 1'b1;
                        state   <= S_PROC;
                    end
                end
                S_PROC: begin
                    // newest sample pairs with tap 0, walking back in time
                    if (issue) begin
                        k     <= k + 1'b1;
                        s_idx <= ring_prev(s_idx);
                    end else if (pair_vld == '0) begin
                        state <= S_OUT;
                    end
                end
                S_OUT: begin
                    if (sm_fire) begin
                        state <= sm_tlast ? S_DONE : S_WAIT;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            pair_vld <= '0;
            ap_done  <= 1'b0;
        end else begin
            pair_vld <= {pair_vld[1:0], issue};
            if (sm_fire && sm_tlast) begin
                ap_done <= 1'b1;
            end else if (status_rd) begin
                ap_done <= 1'b0;
            end
        end
    end

    ////////////////////
    // memory requests

    always_comb begin
        tap_seq_req = '0;
        sample_req  = '0;
        case (state)
            S_CLEAR: begin
                // coefficients are only wiped after reset
                tap_seq_req.en   = boot;
                tap_seq_req.we   = boot;
                tap_seq_req.addr = 8'(clr_cnt);
                sample_req.en    = 1'b1;
                sample_req.we    = 1'b1;
                sample_req.addr  = 8'(clr_cnt);
            end
            S_WAIT: begin
                sample_req.en    = ss_fire;
                sample_req.we    = ss_fire;
                sample_req.addr  = 8'(wptr);
                sample_req.wdata = ss_tdata;
            end
            S_PROC: begin
                tap_seq_req.en   = issue;
                tap_seq_req.addr = 8'(k);
                sample_req.en    = issue;
                sample_req.addr  = 8'(s_idx);
            end
            default: begin
            end
        endcase
    end

endmodule

/* source/fir_top.sv */
`timescale 1ns/1ns

module fir_top
    import fir_pkg::*;
#(
    parameter int TAP_MAX = 32
) (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    // register write
    input  logic              awvalid,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              wvalid,
    input  logic [DATA_W-1:0] wdata,
    output logic              awready,
    output logic              wready,
    // register read
    input  logic              arvalid,
    input  logic [ADDR_W-1:0] araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [DATA_W-1:0] rdata,
    input  logic              rready,
    // sample stream in, run length comes from data_len
    input  logic              ss_tvalid,
    input  logic [DATA_W-1:0] ss_tdata,
    input  logic              ss_tlast,
    output logic              ss_tready,
    // result stream out
    output logic              sm_tvalid,
    output logic [DATA_W-1:0] sm_tdata,
    output logic              sm_tlast,
    input  logic              sm_tready
);

    fir_cfg_t          cfg;
    logic              ap_start;
    logic              status_rd;
    logic              ap_done;
    logic              ap_idle;
    ram_req_t          tap_req;
    ram_req_t          tap_seq_req;
    ram_req_t          tap_ram_req;
    ram_req_t          sample_req;
    logic [DATA_W-1:0] tap_word;
    logic [DATA_W-1:0] sample_word;
    logic              acc_clear;
    logic              acc_en;

    fir_regs #(
        .TAP_MAX (TAP_MAX)
    ) i_fir_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .ap_done    (ap_done),
        .ap_idle    (ap_idle),
        .cfg        (cfg),
        .ap_start   (ap_start),
        .status_rd  (status_rd),
        .tap_req    (tap_req)
    );

    fir_sequencer #(
        .TAP_MAX (TAP_MAX)
    ) i_fir_sequencer (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .cfg         (cfg),
        .ap_start    (ap_start),
        .status_rd   (status_rd),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tready   (ss_tready),
        .sm_tready   (sm_tready),
        .sm_tvalid   (sm_tvalid),
        .sm_tlast    (sm_tlast),
        .ap_done     (ap_done),
        .ap_idle     (ap_idle),
        .tap_seq_req (tap_seq_req),
        .sample_req  (sample_req),
        .acc_clear   (acc_clear),
        .acc_en      (acc_en)
    );

    // coefficients are loaded over the register port only while idle
    assign tap_ram_req = ap_idle ? tap_req : tap_seq_req;

    word_ram #(
        .DEPTH (TAP_MAX)
    ) i_tap_ram (
        .axis_clk (axis_clk),
        .req      (tap_ram_req),
        .rdata    (tap_word)
    );

    word_ram #(
        .DEPTH (TAP_MAX)
    ) i_sample_ram (
        .axis_clk (axis_clk),
        .req      (sample_req),
        .rdata    (sample_word)
    );

    fir_mac i_fir_mac (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .tap_word    (tap_word),
        .sample_word (sample_word),
        .acc_clear   (acc_clear),
        .acc_en      (acc_en),
        .acc         (sm_tdata)
    );

endmodule

/* source/word_ram.sv */
`timescale 1ns/1ns

module word_ram #(
    parameter int DEPTH = 32
) (
    input  logic                       axis_clk,
    input  fir_pkg::ram_req_t          req,
    output logic [fir_pkg::DATA_W-1:0] rdata
);

    localparam int IW = $clog2(DEPTH);

    logic [fir_pkg::DATA_W-1:0] mem [DEPTH];
    logic [IW-1:0]              idx;

    assign idx = req.addr[IW-1:0];

    // read returns the old word on a write
    always_ff @(posedge axis_clk) begin
        if (req.en) begin
            if (req.we) begin
                mem[idx] <= req.wdata;
            end
            rdata <= mem[idx];
        end
    end

endmodule

/* test/tb_fir.sv */
`timescale 1ns/1ns

module tb_fir
    import fir_pkg::*;
;

    localparam int TAP_MAX = 32;
    // samples over all runs, and a margin for register traffic and clearing
    localparam int TOTAL_SAMPLES   = 40 + 30 + 20 + 12;
    localparam int CFG_CYCLES      = 2000;
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * (TAP_MAX + 10) + CFG_CYCLES;

    logic              axis_clk;
    logic              axis_rst_n;
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic              awready;
    logic              wready;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic              rready;
    logic              ss_tvalid;
    logic [DATA_W-1:0] ss_tdata;
    logic              ss_tlast;
    logic              ss_tready;
    logic              sm_tvalid;
    logic [DATA_W-1:0] sm_tdata;
    logic              sm_tlast;
    logic              sm_tready;

    // reference state
    logic [31:0] coef [TAP_MAX];
    logic [31:0] x_hist [$];
    logic [31:0] exp_data [$];
    logic        exp_last [$];
    int          cur_taps;
    string       run_name;

    int          errors;
    int          checked;
    int          run_out_cnt;
    int          ack_out_cnt;
    logic        bp_on;
    logic        held;
    logic [31:0] held_data;
    logic [15:0] data_lfsr;
    logic [15:0] bp_lfsr;

    fir_top #(
        .TAP_MAX (TAP_MAX)
    ) i_fir_top (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

    ////////////////////
    // models

    // galois lfsr on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] lfsr_take(inout logic [15:0] state, input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], state[0]};
            if (state[0]) begin
                state = (state >> 1) ^ 16'hB400;
            end else begin
                state = state >> 1;
            end
        end
        return value;
    endfunction

    // y[n] = sum of h[k] * x[n-k] with zero history before the run
    function automatic logic [31:0] fir_ref(input int n);
        logic [31:0] sum;
        sum = '0;
        for (int k = 0; k < cur_taps; k++) begin
            if (n - k >= 0) begin
                sum = sum + coef[k] * x_hist[n - k];
            end
        end
        return sum;
    endfunction

    ////////////////////
    // register port

    task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        @(posedge axis_clk);
        #2;
        while (!awready) begin
            @(posedge axis_clk);
            #2;
        end
        if (wready !== 1'b1) begin
            errors++;
            $display("wready did not rise together with awready for address %h", addr);
        end
        // the write lands on the edge after the ack
        ack_out_cnt = run_out_cnt;
        @(posedge axis_clk);
        #2;
        if (awready !== 1'b0 || wready !== 1'b0) begin
            errors++;
            $display("write acknowledge for address %h lasted more than one cycle", addr);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        @(posedge axis_clk);
        #2;
        while (!arready) begin
            @(posedge axis_clk);
            #2;
        end
        @(posedge axis_clk);
        #2;
        arvalid = 1'b0;
        while (!rvalid) begin
            @(posedge axis_clk);
            #2;
        end
        data = rdata;
        @(posedge axis_clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [ADDR_W-1:0] addr,
                             input logic [31:0] expected);
        logic [31:0] value;
        reg_read(addr, value);
        if (value !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, value);
        end
    endtask

    task automatic load_coefs(input int n);
        for (int k = 0; k < n; k++) begin
            coef[k] = lfsr_take(data_lfsr, 16);
            reg_write(REG_TAP_BASE + ADDR_W'(4 * k), coef[k]);
        end
    endtask

    task automatic configure(input int len, input int taps);
        reg_write(REG_DATA_LEN, 32'(len));
        reg_write(REG_TAP_NUM, 32'(taps));
        cur_taps = taps;
    endtask

    ////////////////////
    // runs

    task automatic run_filter(input string name, input int n);
        run_name = name;
        x_hist.delete();
        for (int i = 0; i < n; i++) begin
            x_hist.push_back(lfsr_take(data_lfsr, 16));
        end
        for (int i = 0; i < n; i++) begin
            exp_data.push_back(fir_ref(i));
            exp_last.push_back(i == n - 1);
        end
        run_out_cnt = 0;
        reg_write(REG_AP_CTRL, 32'h1);
        for (int i = 0; i < n; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = x_hist[i];
            ss_tlast  = (i == n - 1);
            @(posedge axis_clk);
            #2;
            while (!ss_tready) begin
                @(posedge axis_clk);
                #2;
            end
            @(posedge axis_clk);
            #2;
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
        wait (run_out_cnt == n);
        @(posedge axis_clk);
        #2;
    endtask

    ////////////////////
    // clock, back-pressure, watchdog

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    initial begin
        logic [31:0] bit_word;
        forever begin
            @(posedge axis_clk);
            #2;
            if (bp_on) begin
                bit_word  = lfsr_take(bp_lfsr, 1);
                sm_tready = bit_word[0];
            end else begin
                sm_tready = 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge axis_clk);
        $display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////
    // output comparison

    // sampled mid-cycle before the transfer edge
    always @(negedge axis_clk) begin
        if (axis_rst_n && sm_tvalid) begin
            if (held && sm_tdata !== held_data) begin
                errors++;
                $display("Error %s hold: expected %h, actual %h", run_name, held_data, sm_tdata);
            end
            if (sm_tready) begin
                held = 1'b0;
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("output %h arrived with no result expected", sm_tdata);
                end else begin
                    if (sm_tdata !== exp_data[0]) begin
                        errors++;
                        $display("Error %s out %0d: expected %h, actual %h",
                                 run_name, run_out_cnt, exp_data[0], sm_tdata);
                    end
                    if (sm_tlast !== exp_last[0]) begin
                        errors++;
                        $display("Error %s last %0d: expected %b, actual %b",
                                 run_name, run_out_cnt, exp_last[0], sm_tlast);
                    end
                    void'(exp_data.pop_front());
                    void'(exp_last.pop_front());
                end
                checked++;
                run_out_cnt++;
            end else begin
                held      = 1'b1;
                held_data = sm_tdata;
            end
        end
    end

    ////////////////////
    // stimulus

    initial begin
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b1;
        bp_on      = 1'b0;
        held       = 1'b0;
        held_data  = '0;
        errors     = 0;
        checked    = 0;
        run_out_cnt = 0;
        ack_out_cnt = 0;
        cur_taps   = 0;
        data_lfsr  = 16'd65;
        bp_lfsr    = 16'd65;
        for (int k = 0; k < TAP_MAX; k++) begin
            coef[k] = '0;
        end
        repeat (3) @(posedge axis_clk);
        #2;
        axis_rst_n = 1'b1;

        // both rams are wiped over TAP_MAX cycles after reset
        repeat (TAP_MAX + 2) @(posedge axis_clk);
        #2;
        check_reg("status_after_reset", REG_AP_CTRL, 32'h4);

        load_coefs(11);
        configure(40, 11);
        check_reg("data_len_readback", REG_DATA_LEN, 32'd40);
        check_reg("tap_num_readback", REG_TAP_NUM, 32'd11);

        run_filter("stream", 40);
        check_reg("status_done_stream", REG_AP_CTRL, 32'h6);

        configure(30, 11);
        bp_on = 1'b1;
        run_filter("backpressure", 30);
        bp_on = 1'b0;

        // done only clears on the read
        check_reg("status_done", REG_AP_CTRL, 32'h6);
        check_reg("status_cleared", REG_AP_CTRL, 32'h4);

        load_coefs(32);
        configure(20, 32);
        run_filter("history", 20);

        // tap count write held off until the run is over
        reg_write(REG_DATA_LEN, 32'd12);
        run_out_cnt = 0;
        fork
            run_filter("busy_write", 12);
            begin
                wait (run_out_cnt >= 3);
                @(posedge axis_clk);
                #2;
                reg_write(REG_TAP_NUM, 32'd7);
                if (ack_out_cnt != 12) begin
                    errors++;
                    $display("Error busy_write ack: expected %0d outputs, actual %0d",
                             12, ack_out_cnt);
                end
            end
        join
        check_reg("tap_num_after_run", REG_TAP_NUM, 32'd7);

        if (exp_data.size() != 0) begin
            errors++;
            $display("%0d expected outputs never arrived", exp_data.size());
        end
        $display("outputs checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
